/* tb.f */
common/core_pkg.sv
common/isa_pkg.sv
common/stage_if.sv
rtl/id_ex.sv
execute/ex_alu.sv
execute/ex_stage.sv
rtl/hazard_ctrl.sv
rtl/ex_core.sv
testbench/tb_ex_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ex_core -o sim_tb_ex_core
./obj_dir/sim_tb_ex_core | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* testbench/tb_ex_core.sv */
module tb_ex_core;
	import core_pkg::*;
	import isa_pkg::*;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [inst_w-1:0] inst;
		logic inst_valid;
		logic [reg_addr_w-1:0] rs1_addr;
		logic [reg_addr_w-1:0] rs2_addr;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		op1_src_t op1_src;
		op2_src_t op2_src;
		logic [xlen-1:0] imm;
		logic rd_wena;
		logic [reg_addr_w-1:0] rd_waddr;
		logic branch;
		logic jump;
		pc_src_t pc_src;
		logic mem_rena;
		logic mem_wena;
		logic [be_w-1:0] mem_byte_enable;
		alu_op_t alu_op;
		logic exception_flag;
		logic [cause_w-1:0] exception_cause;
	} bundle_t;

	localparam logic [17:0] cond_list = {bgeu, bltu, bge, blt, bne, beq};
	localparam logic [63:0] sign_bit = 64'h8000_0000_0000_0000;

	logic clk;
	logic rst;
	logic hold;
	bundle_t cur;
	bundle_t held;
	logic model_ok = 1'b0;
	logic timed_out = 1'b0;
	logic [31:0] lcg_state;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	stall_code_t dec_stall;
	logic redirect;
	logic [xlen-1:0] redirect_pc;
	logic ex_valid;
	logic [xlen-1:0] ex_pc;
	logic [xlen-1:0] ex_result;
	logic ex_rd_wena;
	logic [reg_addr_w-1:0] ex_rd_waddr;
	logic ex_mem_rena;
	logic ex_mem_wena;
	logic [be_w-1:0] ex_mem_byte_enable;
	logic [xlen-1:0] ex_store_data;
	logic ex_exception_flag;
	logic [cause_w-1:0] ex_exception_cause;

	ex_core i_ex_core (
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.id_pc(cur.pc),
		.id_inst(cur.inst),
		.id_inst_valid(cur.inst_valid),
		.id_rs1_addr(cur.rs1_addr),
		.id_rs2_addr(cur.rs2_addr),
		.id_rs1_data(cur.rs1_data),
		.id_rs2_data(cur.rs2_data),
		.id_op1_src(cur.op1_src),
		.id_op2_src(cur.op2_src),
		.id_imm(cur.imm),
		.id_rd_wena(cur.rd_wena),
		.id_rd_waddr(cur.rd_waddr),
		.id_branch(cur.branch),
		.id_jump(cur.jump),
		.id_pc_src(cur.pc_src),
		.id_mem_rena(cur.mem_rena),
		.id_mem_wena(cur.mem_wena),
		.id_mem_byte_enable(cur.mem_byte_enable),
		.id_alu_op(cur.alu_op),
		.id_exception_flag(cur.exception_flag),
		.id_exception_cause(cur.exception_cause),
		.dec_stall(dec_stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_valid(ex_valid),
		.ex_pc(ex_pc),
		.ex_result(ex_result),
		.ex_rd_wena(ex_rd_wena),
		.ex_rd_waddr(ex_rd_waddr),
		.ex_mem_rena(ex_mem_rena),
		.ex_mem_wena(ex_mem_wena),
		.ex_mem_byte_enable(ex_mem_byte_enable),
		.ex_store_data(ex_store_data),
		.ex_exception_flag(ex_exception_flag),
		.ex_exception_cause(ex_exception_cause)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [63:0] rand_word();
		return {lcg_next(), lcg_next()};
	endfunction

	// plain alu bundle without a memory read so it never stalls
	function automatic bundle_t rand_bundle();
		bundle_t b;
		logic [31:0] r;
		b = '0;
		r = lcg_next();
		b.pc = rand_word();
		b.pc[1:0] = 2'b00;
		b.inst = lcg_next();
		b.inst_valid = 1'b1;
		b.rs1_addr = r[4:0];
		b.rs2_addr = r[9:5];
		b.rd_waddr = r[14:10];
		b.rd_wena = 1'b1;
		b.mem_wena = r[15];
		b.mem_byte_enable = r[23:16];
		b.exception_cause = r[28:24];
		b.rs1_data = rand_word();
		b.rs2_data = rand_word();
		b.imm = rand_word();
		return b;
	endfunction

	// signed compare done by flipping the sign bit
	function automatic logic [63:0] ref_alu(alu_op_t op, logic [63:0] a, logic [63:0] b);
		logic [5:0] sh;
		sh = b[5:0];
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			alu_sll: return a << sh;
			alu_srl: return a >> sh;
			alu_sra: return (a >> sh) | (a[63] ? ~(~64'd0 >> sh) : 64'd0);
			alu_slt: return {63'd0, (a ^ sign_bit) < (b ^ sign_bit)};
			alu_sltu: return {63'd0, a < b};
			alu_pass_b: return b;
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic ref_taken(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
		case (f3)
			beq: return a == b;
			bne: return a != b;
			blt: return (a ^ sign_bit) < (b ^ sign_bit);
			bge: return !((a ^ sign_bit) < (b ^ sign_bit));
			bltu: return a < b;
			bgeu: return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [63:0] exp_op_a();
		return (held.op1_src == op1_pc) ? held.pc : held.rs1_data;
	endfunction

	function automatic logic [63:0] exp_op_b();
		case (held.op2_src)
			op2_rs2: return held.rs2_data;
			op2_imm: return held.imm;
			op2_four: return 64'd4;
			default: return 64'd0;
		endcase
	endfunction

	function automatic logic exp_redirect();
		return held.inst_valid && (held.jump || (held.branch &&
			ref_taken(held.inst[14:12], held.rs1_data, held.rs2_data)));
	endfunction

	function automatic logic [63:0] exp_target();
		if (held.pc_src == pc_rel)
			return held.pc + held.imm;
		return (held.rs1_data + held.imm) & ~64'd1;
	endfunction

	function automatic logic exp_load_use();
		return held.inst_valid && held.mem_rena && held.rd_wena && held.rd_waddr != 5'd0 &&
			cur.inst_valid && (held.rd_waddr == cur.rs1_addr || held.rd_waddr == cur.rs2_addr);
	endfunction

	// priority is hold then redirect then load-use
	function automatic stall_code_t exp_id_ex_stall();
		if (hold)
			return stall_keep;
		if (exp_redirect() || exp_load_use())
			return stall_zero;
		return stall_next;
	endfunction

	function automatic stall_code_t exp_dec_stall();
		if (hold)
			return stall_keep;
		if (exp_redirect())
			return stall_zero;
		if (exp_load_use())
			return stall_keep;
		return stall_next;
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// one-entry model of the pipeline register
	always @(posedge clk) begin : model_update
		if (rst) begin
			held = '0;
			model_ok = 1'b1;
		end else begin
			case (exp_id_ex_stall())
				stall_next: held = cur;
				stall_keep: begin
				end
				default: begin
					held.pc = '0;
					held.inst_valid = 1'b0;
					held.rd_wena = 1'b0;
					held.branch = 1'b0;
					held.jump = 1'b0;
					held.mem_rena = 1'b0;
					held.mem_wena = 1'b0;
					held.exception_flag = 1'b0;
				end
			endcase
		end
	end

	// mid-cycle compare of every output against the model
	always @(negedge clk) begin : output_check
		if (model_ok) begin
			check_val("dec_stall", 64'(exp_dec_stall()), 64'(dec_stall));
			check_val("redirect", 64'(exp_redirect()), 64'(redirect));
			check_val("redirect_pc", exp_target(), redirect_pc);
			check_val("ex_result", ref_alu(held.alu_op, exp_op_a(), exp_op_b()), ex_result);
			check_val("ex_valid", 64'(held.inst_valid), 64'(ex_valid));
			check_val("ex_pc", held.pc, ex_pc);
			check_val("ex_rd_wena", 64'(held.rd_wena), 64'(ex_rd_wena));
			check_val("ex_rd_waddr", 64'(held.rd_waddr), 64'(ex_rd_waddr));
			check_val("ex_mem_rena", 64'(held.mem_rena), 64'(ex_mem_rena));
			check_val("ex_mem_wena", 64'(held.mem_wena), 64'(ex_mem_wena));
			check_val("ex_mem_byte_enable", 64'(held.mem_byte_enable),
				64'(ex_mem_byte_enable));
			check_val("ex_store_data", held.rs2_data, ex_store_data);
			check_val("ex_exception_flag", 64'(held.exception_flag), 64'(ex_exception_flag));
			check_val("ex_exception_cause", 64'(held.exception_cause),
				64'(ex_exception_cause));
		end
	end

	hold_keeps: assert property (@(posedge clk) disable iff (rst)
		hold |-> dec_stall == stall_keep)
	else begin
		errors++;
		$display("[FAIL] t=%0t dec_stall expected %0d got %0d", $time, stall_keep, dec_stall);
	end

	redirect_flushes: assert property (@(posedge clk) disable iff (rst)
		(redirect && !hold) |-> dec_stall == stall_zero)
	else begin
		errors++;
		$display("[FAIL] t=%0t dec_stall expected %0d got %0d", $time, stall_zero, dec_stall);
	end

	// re-applies the bundle while decode is told to hold
	task automatic issue(input bundle_t b);
		int n;
		n = 0;
		cur = b;
		@(negedge clk);
		while (dec_stall == stall_keep && !timed_out) begin
			n++;
			if (n > 20) begin
				timed_out = 1'b1;
				$display("timeout: bundle at pc %h never accepted by decode", b.pc);
			end
			@(posedge clk);
			#10;
			@(negedge clk);
		end
		@(posedge clk);
		#10;
	endtask

	task automatic wait_for_pc(input logic [63:0] pc);
		int n;
		n = 0;
		@(negedge clk);
		while (!(ex_valid && ex_pc == pc) && !timed_out) begin
			n++;
			if (n > 20) begin
				timed_out = 1'b1;
				$display("timeout: bundle at pc %h never reached execute", pc);
			end
			@(posedge clk);
			#10;
			@(negedge clk);
		end
		@(posedge clk);
		#10;
	endtask

	task automatic bubble_pair(input bundle_t ld, input bundle_t dep);
		issue(ld);
		cur = dep;
		@(negedge clk);
		check_val("dec_stall", 64'(stall_keep), 64'(dec_stall));
		@(posedge clk);
		#10;
		@(negedge clk);
		check_val("ex_valid", 64'd0, 64'(ex_valid));
		check_val("ex_rd_wena", 64'd0, 64'(ex_rd_wena));
		check_val("ex_mem_rena", 64'd0, 64'(ex_mem_rena));
		check_val("ex_mem_wena", 64'd0, 64'(ex_mem_wena));
		check_val("ex_exception_flag", 64'd0, 64'(ex_exception_flag));
		@(posedge clk);
		#10;
		cur = '0;
		wait_for_pc(dep.pc);
	endtask

	task automatic report_test(input string name, input int e0);
		tests++;
		if (errors == e0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - e0);
	endtask

	task automatic reset_test();
		int e0;
		e0 = errors;
		repeat (8) @(posedge clk);
		#10;
		rst = 1'b0;
		@(negedge clk);
		check_val("ex_valid", 64'd0, 64'(ex_valid));
		check_val("redirect", 64'd0, 64'(redirect));
		check_val("dec_stall", 64'(stall_next), 64'(dec_stall));
		@(posedge clk);
		#10;
		report_test("reset", e0);
	endtask

	task automatic alu_test();
		bundle_t b;
		int e0;
		e0 = errors;
		for (int op = 0; op < 11; op++) begin
			for (int s1 = 0; s1 < 2; s1++) begin
				for (int s2 = 0; s2 < 3; s2++) begin
					b = rand_bundle();
					b.alu_op = alu_op_t'(op[3:0]);
					b.op1_src = op1_src_t'(s1[0]);
					b.op2_src = op2_src_t'(s2[1:0]);
					issue(b);
				end
			end
		end
		cur = '0;
		@(posedge clk);
		#10;
		report_test("alu", e0);
	endtask

	task automatic load_use_test();
		bundle_t ld;
		bundle_t dep;
		int e0;
		e0 = errors;
		ld = rand_bundle();
		ld.mem_rena = 1'b1;
		ld.rd_waddr = 5'd9;
		ld.op2_src = op2_imm;
		dep = rand_bundle();
		dep.rs2_addr = 5'd9;
		bubble_pair(ld, dep);
		// x0 never creates a dependency
		ld.rd_waddr = 5'd0;
		dep = rand_bundle();
		dep.rs1_addr = 5'd0;
		dep.rs2_addr = 5'd0;
		issue(ld);
		cur = dep;
		@(negedge clk);
		check_val("dec_stall", 64'(stall_next), 64'(dec_stall));
		@(posedge clk);
		#10;
		cur = '0;
		wait_for_pc(dep.pc);
		report_test("load_use", e0);
	endtask

	task automatic branch_test();
		bundle_t b;
		logic [63:0] x;
		logic [63:0] neg;
		logic [63:0] pos;
		int e0;
		e0 = errors;
		for (int c = 0; c < 6; c++) begin
			// equal operands, then negative against positive, then the reverse
			for (int k = 0; k < 3; k++) begin
				x = rand_word();
				neg = x | sign_bit;
				pos = x & ~sign_bit;
				b = rand_bundle();
				b.rd_wena = 1'b0;
				b.branch = 1'b1;
				b.inst[14:12] = cond_list[c*3 +: 3];
				b.rs1_data = (k == 0) ? x : ((k == 1) ? neg : pos);
				b.rs2_data = (k == 0) ? x : ((k == 1) ? pos : neg);
				issue(b);
				issue(rand_bundle());
			end
		end
		for (int p = 0; p < 2; p++) begin
			b = rand_bundle();
			b.jump = 1'b1;
			b.pc_src = pc_src_t'(p[0]);
			b.op1_src = op1_pc;
			b.op2_src = op2_four;
			issue(b);
			issue(rand_bundle());
		end
		cur = '0;
		@(posedge clk);
		#10;
		report_test("branch", e0);
	endtask

	task automatic hold_test();
		bundle_t a;
		bundle_t b;
		logic [63:0] exp_pc;
		logic [63:0] exp_res;
		int e0;
		e0 = errors;
		a = rand_bundle();
		b = rand_bundle();
		issue(a);
		// the model now holds bundle a
		exp_pc = a.pc;
		exp_res = ref_alu(held.alu_op, exp_op_a(), exp_op_b());
		cur = b;
		hold = 1'b1;
		@(negedge clk);
		check_val("ex_pc", exp_pc, ex_pc);
		check_val("ex_result", exp_res, ex_result);
		repeat (3) begin
			@(posedge clk);
			#10;
			@(negedge clk);
			check_val("ex_pc", exp_pc, ex_pc);
			check_val("ex_result", exp_res, ex_result);
		end
		@(posedge clk);
		#10;
		hold = 1'b0;
		@(negedge clk);
		check_val("ex_pc", a.pc, ex_pc);
		@(posedge clk);
		#10;
		cur = '0;
		wait_for_pc(b.pc);
		report_test("hold", e0);
	endtask

	task automatic exception_test();
		bundle_t e;
		bundle_t dep;
		int e0;
		e0 = errors;
		e = rand_bundle();
		e.exception_flag = 1'b1;
		issue(e);
		cur = '0;
		@(negedge clk);
		check_val("ex_exception_flag", 64'd1, 64'(ex_exception_flag));
		check_val("ex_exception_cause", 64'(e.exception_cause), 64'(ex_exception_cause));
		@(posedge clk);
		#10;
		// faulting load then a reader so the bubble drops the flag
		e = rand_bundle();
		e.exception_flag = 1'b1;
		e.mem_rena = 1'b1;
		e.rd_waddr = 5'd12;
		dep = rand_bundle();
		dep.rs1_addr = 5'd12;
		bubble_pair(e, dep);
		report_test("exception", e0);
	endtask

	initial begin : watchdog
		int n;
		n = 0;
		while (n < 2000) begin
			@(posedge clk);
			n++;
		end
		$display("simulation did not finish within 2000 cycles");
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		cur = '0;
		hold = 1'b0;
		rst = 1'b1;
		lcg_state = 32'hfbc6bb15;
		reset_test();
		alu_test();
		load_use_test();
		branch_test();
		hold_test();
		exception_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* rtl/ex_core.sv */
module ex_core (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic [core_pkg::xlen-1:0] id_pc,
	input logic [core_pkg::inst_w-1:0] id_inst,
	input logic id_inst_valid,
	input logic [core_pkg::reg_addr_w-1:0] id_rs1_addr,
	input logic [core_pkg::reg_addr_w-1:0] id_rs2_addr,
	input logic [core_pkg::xlen-1:0] id_rs1_data,
	input logic [core_pkg::xlen-1:0] id_rs2_data,
	input isa_pkg::op1_src_t id_op1_src,
	input isa_pkg::op2_src_t id_op2_src,
	input logic [core_pkg::xlen-1:0] id_imm,
	input logic id_rd_wena,
	input logic [core_pkg::reg_addr_w-1:0] id_rd_waddr,
	input logic id_branch,
	input logic id_jump,
	input isa_pkg::pc_src_t id_pc_src,
	input logic id_mem_rena,
	input logic id_mem_wena,
	input logic [core_pkg::be_w-1:0] id_mem_byte_enable,
	input isa_pkg::alu_op_t id_alu_op,
	input logic id_exception_flag,
	input logic [core_pkg::cause_w-1:0] id_exception_cause,
	output core_pkg::stall_code_t dec_stall,
	output logic redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output logic ex_valid,
	output logic [core_pkg::xlen-1:0] ex_pc,
	output logic [core_pkg::xlen-1:0] ex_result,
	output logic ex_rd_wena,
	output logic [core_pkg::reg_addr_w-1:0] ex_rd_waddr,
	output logic ex_mem_rena,
	output logic ex_mem_wena,
	output logic [core_pkg::be_w-1:0] ex_mem_byte_enable,
	output logic [core_pkg::xlen-1:0] ex_store_data,
	output logic ex_exception_flag,
	output logic [core_pkg::cause_w-1:0] ex_exception_cause
);
	import core_pkg::*;

	stall_code_t id_ex_stall;

	stage_if dec_bus ();
	stage_if ex_bus ();

	// incoming bundle from decode
	assign dec_bus.pc = id_pc;
	assign dec_bus.inst = id_inst;
	assign dec_bus.inst_valid = id_inst_valid;
	assign dec_bus.rs1_addr = id_rs1_addr;
	assign dec_bus.rs2_addr = id_rs2_addr;
	assign dec_bus.rs1_data = id_rs1_data;
	assign dec_bus.rs2_data = id_rs2_data;
	assign dec_bus.op1_src = id_op1_src;
	assign dec_bus.op2_src = id_op2_src;
	assign dec_bus.imm = id_imm;
	assign dec_bus.rd_wena = id_rd_wena;
	assign dec_bus.rd_waddr = id_rd_waddr;
	assign dec_bus.branch = id_branch;
	assign dec_bus.jump = id_jump;
	assign dec_bus.pc_src = id_pc_src;
	assign dec_bus.mem_rena = id_mem_rena;
	assign dec_bus.mem_wena = id_mem_wena;
	assign dec_bus.mem_byte_enable = id_mem_byte_enable;
	assign dec_bus.alu_op = id_alu_op;
	assign dec_bus.exception_flag = id_exception_flag;
	assign dec_bus.exception_cause = id_exception_cause;

	id_ex i_id_ex (
		.clk(clk),
		.rst(rst),
		.stall(id_ex_stall),
		.dec(dec_bus.consumer),
		.ex(ex_bus.producer)
	);

	ex_stage i_ex_stage (
		.ex(ex_bus.consumer),
		.result(ex_result),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	hazard_ctrl i_hazard_ctrl (
		.hold(hold),
		.redirect(redirect),
		.held(ex_bus.hazard),
		.incoming(dec_bus.hazard),
		.id_ex_stall(id_ex_stall),
		.dec_stall(dec_stall)
	);

	// held bundle toward memory stage
	assign ex_valid = ex_bus.inst_valid;
	assign ex_pc = ex_bus.pc;
	assign ex_rd_wena = ex_bus.rd_wena;
	assign ex_rd_waddr = ex_bus.rd_waddr;
	assign ex_mem_rena = ex_bus.mem_rena;
	assign ex_mem_wena = ex_bus.mem_wena;
	assign ex_mem_byte_enable = ex_bus.mem_byte_enable;
	assign ex_store_data = ex_bus.rs2_data;
	assign ex_exception_flag = ex_bus.exception_flag;
	assign ex_exception_cause = ex_bus.exception_cause;

endmodule

/* rtl/hazard_ctrl.sv */
module hazard_ctrl (
	input logic hold,
	input logic redirect,
	stage_if.hazard held,
	stage_if.hazard incoming,
	output core_pkg::stall_code_t id_ex_stall,
	output core_pkg::stall_code_t dec_stall
);
	import core_pkg::*;

	logic load_use;
	logic rd_match;

	// held load targets a register the incoming instruction reads
	assign rd_match = (held.rd_waddr == incoming.rs1_addr) |
		(held.rd_waddr == incoming.rs2_addr);
	assign load_use = held.inst_valid & held.mem_rena & held.rd_wena &
		(held.rd_waddr != {reg_addr_w{1'b0}}) & incoming.inst_valid & rd_match;

	always_comb begin
		if (hold) begin
			id_ex_stall = stall_keep;
			dec_stall = stall_keep;
		end else if (redirect) begin
			// squash the wrong-path instruction in decode
			id_ex_stall = stall_zero;
			dec_stall = stall_zero;
		end else if (load_use) begin
			id_ex_stall = stall_zero;
			dec_stall = stall_keep;
		end else begin
			id_ex_stall = stall_next;
			dec_stall = stall_next;
		end
	end

endmodule

/* execute/ex_stage.sv */
module ex_stage (
	stage_if.consumer ex,
	output logic [core_pkg::xlen-1:0] result,
	output logic redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc
);
	import core_pkg::*;
	import isa_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] target;
	logic taken;

	assign op_a = (ex.op1_src == op1_pc) ? ex.pc : ex.rs1_data;

	always_comb begin
		case (ex.op2_src)
			op2_rs2: op_b = ex.rs2_data;
			op2_imm: op_b = ex.imm;
			op2_four: op_b = 64'd4;
			default: op_b = zero_word;
		endcase
	end

	ex_alu i_ex_alu (
		.op(ex.alu_op),
		.a(op_a),
		.b(op_b),
		.y(result)
	);

	// condition from funct3
	always_comb begin
		case (ex.inst[14:12])
			beq: taken = ex.rs1_data == ex.rs2_data;
			bne: taken = ex.rs1_data != ex.rs2_data;
			blt: taken = $signed(ex.rs1_data) < $signed(ex.rs2_data);
			bge: taken = $signed(ex.rs1_data) >= $signed(ex.rs2_data);
			bltu: taken = ex.rs1_data < ex.rs2_data;
			bgeu: taken = ex.rs1_data >= ex.rs2_data;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = ex.inst_valid & (ex.jump | (ex.branch & taken));

	// jalr target drops bit 0
	assign target = (ex.pc_src == pc_rel) ? ex.pc + ex.imm : ex.rs1_data + ex.imm;
	assign redirect_pc = (ex.pc_src == rs1_rel) ? {target[xlen-1:1], 1'b0} : target;

endmodule

/* execute/ex_alu.sv */
module ex_alu (
	input isa_pkg::alu_op_t op,
	input logic [core_pkg::xlen-1:0] a,
	input logic [core_pkg::xlen-1:0] b,
	output logic [core_pkg::xlen-1:0] y
);
	import core_pkg::*;
	import isa_pkg::*;

	logic [5:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	// rv64 shifts only look at six bits
	assign shamt = b[5:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or: y = a | b;
			alu_xor: y = a ^ b;
			alu_sll: y = a << shamt;
			alu_srl: y = a >> shamt;
			alu_sra: y = $signed(a) >>> shamt;
			alu_slt: y = {{(xlen - 1){1'b0}}, lt_signed};
			alu_sltu: y = {{(xlen - 1){1'b0}}, lt_unsigned};
			// lui style, immediate straight through
			alu_pass_b: y = b;
			default: y = zero_word;
		endcase
	end

endmodule

/* rtl/id_ex.sv */
module id_ex (
	input logic clk,
	input logic rst,
	input core_pkg::stall_code_t stall,
	stage_if.consumer dec,
	stage_if.producer ex
);
	import core_pkg::*;
	import isa_pkg::*;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex.pc <= zero_word;
			ex.inst <= '0;
			ex.inst_valid <= 1'b0;
			ex.rs1_addr <= '0;
			ex.rs2_addr <= '0;
			ex.rs1_data <= zero_word;
			ex.rs2_data <= zero_word;
			ex.op1_src <= op1_rs1;
			ex.op2_src <= op2_rs2;
			ex.imm <= zero_word;
			ex.rd_wena <= 1'b0;
			ex.rd_waddr <= '0;
			ex.branch <= 1'b0;
			ex.jump <= 1'b0;
			ex.pc_src <= pc_rel;
			ex.mem_rena <= 1'b0;
			ex.mem_wena <= 1'b0;
			ex.mem_byte_enable <= '0;
			ex.alu_op <= alu_add;
			ex.exception_flag <= 1'b0;
			ex.exception_cause <= '0;
		end else begin
			case (stall)
				stall_next: begin
					ex.pc <= dec.pc;
					ex.inst <= dec.inst;
					ex.inst_valid <= dec.inst_valid;
					ex.rs1_addr <= dec.rs1_addr;
					ex.rs2_addr <= dec.rs2_addr;
					ex.rs1_data <= dec.rs1_data;
					ex.rs2_data <= dec.rs2_data;
					ex.op1_src <= dec.op1_src;
					ex.op2_src <= dec.op2_src;
					ex.imm <= dec.imm;
					ex.rd_wena <= dec.rd_wena;
					ex.rd_waddr <= dec.rd_waddr;
					ex.branch <= dec.branch;
					ex.jump <= dec.jump;
					ex.pc_src <= dec.pc_src;
					ex.mem_rena <= dec.mem_rena;
					ex.mem_wena <= dec.mem_wena;
					ex.mem_byte_enable <= dec.mem_byte_enable;
					ex.alu_op <= dec.alu_op;
					ex.exception_flag <= dec.exception_flag;
					ex.exception_cause <= dec.exception_cause;
				end
				stall_keep: begin
					// hold everything
				end
				default: begin
					// bubble: kill validity and side effects,
					// data fields stay stale and are never acted on
					ex.pc <= zero_word;
					ex.inst_valid <= 1'b0;
					ex.rd_wena <= 1'b0;
					ex.branch <= 1'b0;
					ex.jump <= 1'b0;
					ex.mem_rena <= 1'b0;
					ex.mem_wena <= 1'b0;
					ex.exception_flag <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* common/stage_if.sv */
interface stage_if;
	import core_pkg::*;
	import isa_pkg::*;

	logic [xlen-1:0] pc;
	logic [inst_w-1:0] inst;
	logic inst_valid;
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	op1_src_t op1_src;
	op2_src_t op2_src;
	logic [xlen-1:0] imm;
	logic rd_wena;
	logic [reg_addr_w-1:0] rd_waddr;
	logic branch;
	logic jump;
	pc_src_t pc_src;
	logic mem_rena;
	logic mem_wena;
	logic [be_w-1:0] mem_byte_enable;
	alu_op_t alu_op;
	logic exception_flag;
	logic [cause_w-1:0] exception_cause;

	modport producer (
		output pc, inst, inst_valid, rs1_addr, rs2_addr, rs1_data, rs2_data,
		output op1_src, op2_src, imm, rd_wena, rd_waddr, branch, jump, pc_src,
		output mem_rena, mem_wena, mem_byte_enable, alu_op,
		output exception_flag, exception_cause
	);

	modport consumer (
		input pc, inst, inst_valid, rs1_addr, rs2_addr, rs1_data, rs2_data,
		input op1_src, op2_src, imm, rd_wena, rd_waddr, branch, jump, pc_src,
		input mem_rena, mem_wena, mem_byte_enable, alu_op,
		input exception_flag, exception_cause
	);

	// only what load-use detection needs
	modport hazard (
		input rs1_addr, rs2_addr, mem_rena, rd_wena, rd_waddr, inst_valid
	);

endinterface

/* common/isa_pkg.sv */
package isa_pkg;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_and    = 4'd2,
		alu_or     = 4'd3,
		alu_xor    = 4'd4,
		alu_sll    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_slt    = 4'd8,
		alu_sltu   = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	// first alu operand
	typedef enum logic {
		op1_rs1 = 1'b0,
		op1_pc  = 1'b1
	} op1_src_t;

	// second alu operand, four is the link offset for jumps
	typedef enum logic [1:0] {
		op2_rs2  = 2'b00,
		op2_imm  = 2'b01,
		op2_four = 2'b10
	} op2_src_t;

	// base for the redirect target
	typedef enum logic {
		pc_rel  = 1'b0,
		rs1_rel = 1'b1
	} pc_src_t;

	// branch conditions, funct3 field of the instruction
	localparam logic [2:0] beq  = 3'b000;
	localparam logic [2:0] bne  = 3'b001;
	localparam logic [2:0] blt  = 3'b100;
	localparam logic [2:0] bge  = 3'b101;
	localparam logic [2:0] bltu = 3'b110;
	localparam logic [2:0] bgeu = 3'b111;

endpackage

/* common/core_pkg.sv */
package core_pkg;

	// datapath widths
	localparam int xlen = 64;
	localparam int reg_addr_w = 5;
	localparam int inst_w = 32;
	localparam int be_w = 8;
	localparam int cause_w = 5;

	// pipeline register control, unknown codes act as a bubble
	typedef enum logic [1:0] {
		stall_next = 2'b00,
		stall_keep = 2'b01,
		stall_zero = 2'b10
	} stall_code_t;

	// reset and bubble value for word-wide fields
	localparam logic [xlen-1:0] zero_word = '0;

endpackage
